//--- hw/reduction_params.svh
/*
  Widths and latency of the integer reduction offload unit.
  The tag and op widths are fixed by the request format.
  The latency must match the sum of the stage delays.
*/

`ifndef REDUCTION_PARAMS_SVH
`define REDUCTION_PARAMS_SVH

////////////////////////////////////////////////////////////////////////////
// Datapath widths
////////////////////////////////////////////////////////////////////////////

// Operand and result width
`define RD_DATA_WIDTH 64

// Request tag, returned unchanged with the response
`define RD_TAG_BITS 5

// External op code
`define RD_OP_BITS 4

////////////////////////////////////////////////////////////////////////////
// Timing
////////////////////////////////////////////////////////////////////////////

// Request strobe to response strobe, in cycles
`define RD_LATENCY 4

`endif

//--- hw/reduction_pkg.sv
/*
  Shared types of the reduction offload unit.
  Op codes 9 to 15 are undefined and give an error response.
*/

`default_nettype none

`include "reduction_params.svh"

package reduction_pkg;

  typedef logic [`RD_DATA_WIDTH-1:0] rd_data_t;
  typedef logic [`RD_TAG_BITS-1:0]   rd_tag_t;

  // External op codes
  typedef enum logic [`RD_OP_BITS-1:0] {
    RD_ADD   = 0,
    RD_MUL   = 1,
    RD_MIN_S = 2,
    RD_MAX_S = 3,
    RD_MIN_U = 4,
    RD_MAX_U = 5,
    RD_AND   = 6,
    RD_OR    = 7,
    RD_XOR   = 8
  } rd_op_e;

  // Result select inside the ALU
  typedef enum logic [2:0] {
    SEL_ADD,
    SEL_MUL,
    SEL_MIN,
    SEL_MAX,
    SEL_AND,
    SEL_OR,
    SEL_XOR
  } alu_sel_e;

  typedef struct packed {
    alu_sel_e sel;
    logic     is_signed;
    logic     illegal;
  } alu_ctrl_t;

  typedef struct packed {
    rd_op_e   op;
    rd_tag_t  tag;
    rd_data_t a;
    rd_data_t b;
  } offload_req_t;

  // Decoded request as seen by the ALU
  typedef struct packed {
    alu_ctrl_t ctrl;
    rd_tag_t   tag;
    rd_data_t  a;
    rd_data_t  b;
  } alu_item_t;

  typedef struct packed {
    rd_tag_t  tag;
    rd_data_t result;
    logic     error;
  } offload_resp_t;

endpackage

`default_nettype wire

//--- hw/offload_req_stage.sv
/*
  Input side of the offload unit. One request per cycle, no back-pressure.
  Undefined op codes are flagged illegal and decoded as add.
*/

`timescale 1ns/1ps
`default_nettype none

module offload_req_stage (
  input  logic                       clk_i,
  input  logic                       reset_i,
  input  logic                       req_valid_i,
  input  reduction_pkg::offload_req_t req_i,
  output logic                       item_valid_o,
  output reduction_pkg::alu_item_t   item_o
);

  import reduction_pkg::*;

  alu_ctrl_t ctrl_d;

  ////////////////////////////////////////////////////////////////////////////
  // Op decode
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    ctrl_d.sel       = SEL_ADD;
    ctrl_d.is_signed = 1'b0;
    ctrl_d.illegal   = 1'b0;
    case (req_i.op)
      RD_ADD:   ctrl_d.sel = SEL_ADD;
      RD_MUL:   ctrl_d.sel = SEL_MUL;
      RD_MIN_S: begin
        ctrl_d.sel       = SEL_MIN;
        ctrl_d.is_signed = 1'b1;
      end
      RD_MAX_S: begin
        ctrl_d.sel       = SEL_MAX;
        ctrl_d.is_signed = 1'b1;
      end
      RD_MIN_U: ctrl_d.sel = SEL_MIN;
      RD_MAX_U: ctrl_d.sel = SEL_MAX;
      RD_AND:   ctrl_d.sel = SEL_AND;
      RD_OR:    ctrl_d.sel = SEL_OR;
      RD_XOR:   ctrl_d.sel = SEL_XOR;
      default:  ctrl_d.illegal = 1'b1;
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // Request register
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      item_valid_o <= 1'b0;
    end else begin
      item_valid_o <= req_valid_i;
    end
  end

  // Payload only loads on a request
  always_ff @(posedge clk_i) begin
    if (req_valid_i) begin
      item_o <= '{ctrl: ctrl_d, tag: req_i.tag, a: req_i.a, b: req_i.b};
    end
  end

  assert property (@(posedge clk_i) disable iff (reset_i)
    req_valid_i |-> !$isunknown(req_i.op))
    else $error("req_stage: op code unknown on a request strobe");

endmodule

`default_nettype wire

//--- hw/reduction_alu.sv
/*
  Two-stage 64-bit integer reduction ALU with a fixed latency of two cycles.
  Multiply keeps the low 64 bits only. Add and multiply wrap.
  The illegal bit passes through; the result is not cleared here.
*/

`timescale 1ns/1ps
`default_nettype none

module reduction_alu (
  input  logic                     clk_i,
  input  logic                     reset_i,
  input  logic                     item_valid_i,
  input  reduction_pkg::alu_item_t item_i,
  output logic                     alu_valid_o,
  output reduction_pkg::rd_data_t  alu_result_o,
  output reduction_pkg::rd_tag_t   alu_tag_o,
  output logic                     alu_illegal_o
);

  import reduction_pkg::*;

  logic     s1_valid;
  rd_data_t s1_sum;
  rd_data_t s1_prod;
  rd_data_t s1_and;
  rd_data_t s1_or;
  rd_data_t s1_xor;
  rd_data_t s1_a;
  rd_data_t s1_b;
  logic     s1_lt;
  alu_sel_e s1_sel;
  rd_tag_t  s1_tag;
  logic     s1_illegal;
  rd_data_t result_d;

  ////////////////////////////////////////////////////////////////////////////
  // Stage one: arithmetic, compare and logic
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      s1_valid <= 1'b0;
    end else begin
      s1_valid <= item_valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (item_valid_i) begin
      s1_sum  <= item_i.a + item_i.b;
      s1_prod <= item_i.a * item_i.b;
      s1_and  <= item_i.a & item_i.b;
      s1_or   <= item_i.a | item_i.b;
      s1_xor  <= item_i.a ^ item_i.b;
      // Compare signedness comes from the decoded op
      s1_lt   <= item_i.ctrl.is_signed ? ($signed(item_i.a) < $signed(item_i.b))
                                       : (item_i.a < item_i.b);
      s1_a       <= item_i.a;
      s1_b       <= item_i.b;
      s1_sel     <= item_i.ctrl.sel;
      s1_tag     <= item_i.tag;
      s1_illegal <= item_i.ctrl.illegal;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Stage two: result select
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    case (s1_sel)
      SEL_ADD: result_d = s1_sum;
      SEL_MUL: result_d = s1_prod;
      SEL_MIN: result_d = s1_lt ? s1_a : s1_b;
      SEL_MAX: result_d = s1_lt ? s1_b : s1_a;
      SEL_AND: result_d = s1_and;
      SEL_OR:  result_d = s1_or;
      SEL_XOR: result_d = s1_xor;
      default: result_d = '0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      alu_valid_o <= 1'b0;
    end else begin
      alu_valid_o <= s1_valid;
    end
  end

  always_ff @(posedge clk_i) begin
    if (s1_valid) begin
      alu_result_o  <= result_d;
      alu_tag_o     <= s1_tag;
      alu_illegal_o <= s1_illegal;
    end
  end

  assert property (@(posedge clk_i) disable iff (reset_i)
    alu_valid_o == $past(item_valid_i, 2))
    else $error("alu: valid does not follow input by two cycles");

endmodule

`default_nettype wire

//--- hw/offload_resp_stage.sv
/*
  Output side of the offload unit. Forms the tagged response register.
  resp_o is zero in every cycle without a response strobe.
*/

`timescale 1ns/1ps
`default_nettype none

module offload_resp_stage (
  input  logic                         clk_i,
  input  logic                         reset_i,
  input  logic                         alu_valid_i,
  input  reduction_pkg::rd_data_t      alu_result_i,
  input  reduction_pkg::rd_tag_t       alu_tag_i,
  input  logic                         alu_illegal_i,
  output logic                         resp_valid_o,
  output reduction_pkg::offload_resp_t resp_o
);

  import reduction_pkg::*;

  offload_resp_t resp_d;

  // Illegal ops return zero with the error bit
  always_comb begin
    resp_d = '0;
    if (alu_valid_i) begin
      resp_d.tag    = alu_tag_i;
      resp_d.result = alu_illegal_i ? '0 : alu_result_i;
      resp_d.error  = alu_illegal_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      resp_valid_o <= 1'b0;
      resp_o       <= '0;
    end else begin
      resp_valid_o <= alu_valid_i;
      resp_o       <= resp_d;
    end
  end

  assert property (@(posedge clk_i) disable iff (reset_i)
    (resp_valid_o && resp_o.error) |-> (resp_o.result == '0))
    else $error("resp_stage: error response with nonzero result %h", resp_o.result);

endmodule

`default_nettype wire

//--- hw/reduction_offload_top.sv
/*
  Integer reduction offload unit: decode, two-stage ALU, response.
  Fixed latency of RD_LATENCY cycles, responses in request order.
  No back-pressure; the requester must accept every response strobe.
*/

`timescale 1ns/1ps
`default_nettype none

`include "reduction_params.svh"

module reduction_offload_top (
  input  logic                         clk_i,
  input  logic                         reset_i,
  input  logic                         req_valid_i,
  input  reduction_pkg::offload_req_t  req_i,
  output logic                         resp_valid_o,
  output reduction_pkg::offload_resp_t resp_o
);

  import reduction_pkg::*;

  logic      item_valid;
  alu_item_t item;
  logic      alu_valid;
  rd_data_t  alu_result;
  rd_tag_t   alu_tag;
  logic      alu_illegal;

  offload_req_stage u_req_stage (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .req_valid_i  (req_valid_i),
    .req_i        (req_i),
    .item_valid_o (item_valid),
    .item_o       (item)
  );

  reduction_alu u_alu (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .item_valid_i  (item_valid),
    .item_i        (item),
    .alu_valid_o   (alu_valid),
    .alu_result_o  (alu_result),
    .alu_tag_o     (alu_tag),
    .alu_illegal_o (alu_illegal)
  );

  offload_resp_stage u_resp_stage (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .alu_valid_i   (alu_valid),
    .alu_result_i  (alu_result),
    .alu_tag_i     (alu_tag),
    .alu_illegal_i (alu_illegal),
    .resp_valid_o  (resp_valid_o),
    .resp_o        (resp_o)
  );

  // End to end latency over all three stages
  assert property (@(posedge clk_i) disable iff (reset_i)
    resp_valid_o == $past(req_valid_i, `RD_LATENCY))
    else $error("top: response strobe not %0d cycles after request", `RD_LATENCY);

endmodule

`default_nettype wire

//--- tb/tb_reduction_model.svh
/*
  Reference model of the offload unit, included inside the testbench module.
  Needs reduction_pkg imported and the reduction params defined beforehand.
  Undefined op codes give error high and a zero result.
*/

`ifndef TB_REDUCTION_MODEL_SVH
`define TB_REDUCTION_MODEL_SVH

// Expected responses, oldest first
offload_resp_t exp_q[$];

function automatic offload_resp_t model_response(
  input logic [`RD_OP_BITS-1:0] code,
  input rd_tag_t                tag,
  input rd_data_t               a,
  input rd_data_t               b
);
  offload_resp_t                     r;
  logic signed [`RD_DATA_WIDTH-1:0] sa;
  logic signed [`RD_DATA_WIDTH-1:0] sb;
  sa       = a;
  sb       = b;
  r.tag    = tag;
  r.result = '0;
  r.error  = 1'b0;
  case (code)
    RD_ADD:   r.result = a + b;
    RD_MUL:   r.result = a * b;
    RD_MIN_S: r.result = (sa < sb) ? a : b;
    RD_MAX_S: r.result = (sa < sb) ? b : a;
    RD_MIN_U: r.result = (a < b) ? a : b;
    RD_MAX_U: r.result = (a < b) ? b : a;
    RD_AND:   r.result = a & b;
    RD_OR:    r.result = a | b;
    RD_XOR:   r.result = a ^ b;
    default:  r.error  = 1'b1;
  endcase
  return r;
endfunction

`endif

//--- tb/tb_reduction_offload.sv
/*
  Directed, corner and random requests into the reduction offload unit.
  Expected responses come from the model header, in request order.
  Tags count up from zero and wrap at 32.
*/

`timescale 1ns/1ps
`default_nettype none

`include "reduction_params.svh"

module tb_reduction_offload;

  import reduction_pkg::*;

  `include "tb_reduction_model.svh"

  localparam int RESET_CYCLES = 4;
  localparam int START_IDLE   = 3;
  localparam int N_DIRECTED   = 9;
  localparam int N_CORNER     = 36;
  localparam int N_ILLEGAL    = 7;
  localparam int N_BURST      = 200;
  localparam int N_GAP        = 100;
  localparam int MAX_GAP      = 3;
  localparam int STIM_CYCLES  = RESET_CYCLES + START_IDLE + N_DIRECTED + N_CORNER
                                + N_ILLEGAL + N_BURST + N_GAP * (MAX_GAP + 1);
  localparam int WATCHDOG_CYCLES = STIM_CYCLES + `RD_LATENCY + 20;

  logic          clk = 1'b0;
  logic          reset;
  logic          req_valid;
  offload_req_t  req;
  logic          resp_valid;
  offload_resp_t resp;

  rd_tag_t       next_tag;
  int            req_count = 0;
  int            resp_count = 0;
  offload_resp_t exp_head;
  logic          exp_valid;
  rd_data_t      corners [6];

  reduction_offload_top DUT (
    .clk_i        (clk),
    .reset_i      (reset),
    .req_valid_i  (req_valid),
    .req_i        (req),
    .resp_valid_o (resp_valid),
    .resp_o       (resp)
  );

  always #50 clk = ~clk;

  task automatic stop_with_failure(input string what);
    $display("%s", what);
    $display("TEST RESULT: FAIL");
    $fatal(1, "stopping on first error");
  endtask

  task automatic report_mismatch(input string name, input logic [63:0] got,
                                 input logic [63:0] expected);
    stop_with_failure($sformatf("mismatch %s: got %0h expected %0h", name, got, expected));
  endtask

  function automatic rd_data_t rand_operand();
    return {$urandom(), $urandom()};
  endfunction

  task automatic send_request(input logic [3:0] code, input rd_data_t a, input rd_data_t b);
    offload_req_t r;
    r.op  = rd_op_e'(code);
    r.tag = next_tag;
    r.a   = a;
    r.b   = b;
    req_valid <= 1'b1;
    req       <= r;
    exp_q.push_back(model_response(code, next_tag, a, b));
    next_tag  = next_tag + 1'b1;
    req_count = req_count + 1;
    @(posedge clk);
  endtask

  task automatic idle_cycles(input int n);
    if (n > 0) begin
      req_valid <= 1'b0;
      repeat (n) @(posedge clk);
    end
  endtask

  // Queue head for the response shown in this cycle
  always @(negedge clk) begin
    if (!reset && resp_valid) begin
      resp_count = resp_count + 1;
      exp_valid  = (exp_q.size() != 0);
      if (exp_valid) begin
        exp_head = exp_q.pop_front();
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Response checks
  ////////////////////////////////////////////////////////////////////////////

  assert property (@(posedge clk) disable iff (reset)
    resp_valid == $past(req_valid, `RD_LATENCY))
    else stop_with_failure("response strobe not exactly four cycles after a request");

  assert property (@(posedge clk) disable iff (reset)
    resp_valid |-> exp_valid)
    else stop_with_failure("response strobe arrived with no request outstanding");

  assert property (@(posedge clk) disable iff (reset)
    (resp_valid && exp_valid) |-> resp.tag == exp_head.tag)
    else report_mismatch("resp_o.tag", $sampled(resp.tag), $sampled(exp_head.tag));

  assert property (@(posedge clk) disable iff (reset)
    (resp_valid && exp_valid) |-> resp.result == exp_head.result)
    else report_mismatch("resp_o.result", $sampled(resp.result), $sampled(exp_head.result));

  assert property (@(posedge clk) disable iff (reset)
    (resp_valid && exp_valid) |-> resp.error == exp_head.error)
    else report_mismatch("resp_o.error", $sampled(resp.error), $sampled(exp_head.error));

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    int gap;
    void'($urandom(32'hbc93));
    reset     = 1'b1;
    req_valid = 1'b0;
    req       = '0;
    next_tag  = '0;
    exp_valid = 1'b0;
    exp_head  = '0;
    corners   = '{64'h8000_0000_0000_0000, 64'hffff_ffff_ffff_ffff,
                  64'h7fff_ffff_ffff_ffff, 64'h0000_0000_0000_0001,
                  64'h0000_0000_0000_0000, 64'h8000_0000_0000_0001};
    repeat (RESET_CYCLES) @(posedge clk);
    reset <= 1'b0;
    idle_cycles(START_IDLE);

    for (int i = 0; i < N_DIRECTED; i++) begin
      send_request(4'(i), 64'h0123_4567_89ab_cdef, 64'hfedc_ba98_7654_3210);
    end

    // Top bit set on one side, add through max unsigned
    for (int i = 0; i < 6; i++) begin
      for (int op = 0; op < 6; op++) begin
        send_request(4'(op), corners[i], corners[(i + 3) % 6]);
      end
    end

    for (int c = 9; c < 9 + N_ILLEGAL; c++) begin
      send_request(4'(c), rand_operand(), rand_operand());
    end

    repeat (N_BURST) begin
      send_request(4'($urandom_range(15, 0)), rand_operand(), rand_operand());
    end

    repeat (N_GAP) begin
      gap = $urandom_range(MAX_GAP, 0);
      idle_cycles(gap);
      send_request(4'($urandom_range(15, 0)), rand_operand(), rand_operand());
    end

    req_valid <= 1'b0;
    while (exp_q.size() != 0) @(posedge clk);
    repeat (2) @(posedge clk);

    if (resp_count == req_count) begin
      $display("TEST RESULT: PASS");
      $finish;
    end else begin
      stop_with_failure($sformatf("%0d requests sent but %0d responses seen",
                                  req_count, resp_count));
    end
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    stop_with_failure($sformatf("timeout with %0d responses still outstanding",
                                exp_q.size()));
  end

endmodule

`default_nettype wire

//--- compile.f
+incdir+hw
+incdir+tb
hw/reduction_pkg.sv
hw/offload_req_stage.sv
hw/reduction_alu.sv
hw/offload_resp_stage.sv
hw/reduction_offload_top.sv
tb/tb_reduction_offload.sv
